//--- build.f
common/ir_pkg.sv
input_router/spad.sv
input_router/tile_reader.sv
input_router/ir_controller.sv
input_router/address_generator.sv
input_router/row_router.sv
input_router/row_group.sv
input_router/input_router.sv
verif/input_router_asserts.sv
verif/tb_input_router.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator, run, and decide the result from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_input_router -f build.f
./obj_dir/Vtb_input_router | tee sim.log

if grep -qx "Test passed" sim.log; then
    exit 0
else
    exit 1
fi

//--- verif/tb_input_router.sv
/*
  Random maps, a scratchpad mirror and per-router queues of expected window bytes.
  Every job uses a read range that covers the whole map.
*/
`timescale 1ns/1ps

module tb_input_router;
    import ir_pkg::*;

    localparam int TIMEOUT = 5000;

    logic                      i_clk;
    logic                      i_rst;
    logic                      i_en;
    logic                      i_reg_clear;
    logic                      i_spad_write_en;
    logic                      i_pop_en;
    spad_word_t                i_data_in;
    word_addr_t                i_write_addr;
    word_addr_t                i_start_addr;
    word_addr_t                i_addr_end;
    word_addr_t                i_i_size;
    word_addr_t                i_o_size;
    word_addr_t                i_stride;
    logic                      o_read_done;
    pixel_t [ROUTER_COUNT-1:0] o_data;
    logic [ROUTER_COUNT-1:0]   o_data_valid;
    logic                      o_ready;
    logic                      o_context_done;
    logic                      o_output_done;

    spad_word_t  mirror [2**ADDR_WIDTH];
    pixel_t      expect_q [ROUTER_COUNT][$];
    int unsigned lcg_state = 32'd81612;
    int unsigned pop_rate;
    logic        pop_next;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          ctx_count;
    int          done_count;
    int          read_count;

    input_router dut (.*);

    always #10 i_clk = ~i_clk;

    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 8;
    endfunction

    // Pop chance of pop_rate percent, drawn at the falling edge
    always @(negedge i_clk) begin
        pop_next = (next_rand() % 100) < pop_rate;
    end

    always @(posedge i_clk) begin
        i_pop_en <= pop_next;
    end

    // Compare every popped byte with the head of its router's queue
    always @(negedge i_clk) begin
        pixel_t want;
        if (!i_rst) begin
            for (int r = 0; r < ROUTER_COUNT; r++) begin
                if (o_data_valid[r]) begin
                    if (expect_q[r].size() == 0) begin
                        $display("Router %0d produced a byte that no window asked for", r);
                        errors++;
                    end else begin
                        want = expect_q[r].pop_front();
                        if (o_data[r] !== want) begin
                            $display("CHECK FAILED o_data[%0d] got 0x%02h expected 0x%02h",
                                     r, o_data[r], want);
                            errors++;
                        end
                    end
                end
            end
            if (o_read_done) begin
                read_count++;
            end
            if (o_context_done) begin
                ctx_count++;
            end
            if (o_output_done) begin
                done_count++;
            end
        end
    end

    task automatic abort_on_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("Test failed");
        $finish;
    endtask

    task automatic write_map(input int start, input int nwords);
        spad_word_t w;
        for (int i = 0; i < nwords; i++) begin
            // Sixteen bits per draw so that every byte lane varies
            for (int h = 0; h < SPAD_DATA_WIDTH / 16; h++) begin
                w[h*16 +: 16] = 16'(next_rand());
            end
            @(posedge i_clk);
            i_spad_write_en <= 1'b1;
            i_write_addr    <= word_addr_t'(start + i);
            i_data_in       <= w;
            mirror[word_addr_t'(start + i)] = w;
        end
        @(posedge i_clk);
        i_spad_write_en <= 1'b0;
    endtask

    // Window bytes in pop order, from the byte offset formula of the map
    task automatic load_expected(input int isz, input int osz, input int st, input int start);
        int         off;
        spad_word_t w;
        for (int r = 0; r < ROUTER_COUNT; r++) begin
            expect_q[r].delete();
        end
        for (int oy = 0; oy < osz; oy++) begin
            for (int ox = 0; ox < osz; ox += ROUTER_COUNT) begin
                for (int r = 0; r < ROUTER_COUNT && ox + r < osz; r++) begin
                    for (int k = 0; k < WINDOW_LEN; k++) begin
                        off = (oy * st + k / KERNEL_SIZE) * isz + (ox + r) * st
                            + k % KERNEL_SIZE;
                        w = mirror[word_addr_t'(start + off / LANES)];
                        expect_q[r].push_back(pixel_t'(w >> (DATA_WIDTH * (off % LANES))));
                    end
                end
            end
        end
    endtask

    task automatic start_job(input int isz, input int osz, input int st, input int start);
        load_expected(isz, osz, st, start);
        ctx_count  = 0;
        done_count = 0;
        read_count = 0;
        @(posedge i_clk);
        i_i_size     <= word_addr_t'(isz);
        i_o_size     <= word_addr_t'(osz);
        i_stride     <= word_addr_t'(st);
        i_start_addr <= word_addr_t'(start);
        i_addr_end   <= word_addr_t'(start + (isz * isz - 1) / LANES);
        i_en         <= 1'b1;
        @(posedge i_clk);
        i_en <= 1'b0;
    endtask

    task automatic run_job(input int isz, input int osz, input int st, input int start);
        int t;
        int want_ctx;
        want_ctx = ((osz + ROUTER_COUNT - 1) / ROUTER_COUNT) * osz;
        start_job(isz, osz, st, start);
        t = 0;
        while (done_count == 0 && t < TIMEOUT) begin
            @(posedge i_clk);
            t++;
        end
        if (done_count == 0) begin
            abort_on_timeout("o_output_done");
        end else begin
            if (ctx_count != want_ctx) begin
                $display("Job ended after %0d contexts instead of %0d", ctx_count, want_ctx);
                errors++;
            end
            // One tile read per context
            if (read_count != want_ctx) begin
                $display("Job read its tile %0d times instead of %0d", read_count, want_ctx);
                errors++;
            end
            for (int r = 0; r < ROUTER_COUNT; r++) begin
                if (expect_q[r].size() != 0) begin
                    $display("Router %0d left %0d window bytes unpopped", r,
                             expect_q[r].size());
                    errors++;
                end
            end
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors != err_before) begin
            tests_failed++;
        end
        $display("%-16s %s (%0d errors)", name, (errors == err_before) ? "ok" : "FAILED",
                 errors - err_before);
    endtask

    task automatic abort_job();
        int t;
        pop_rate = 100;
        start_job(8, 6, 1, 0);
        t = 0;
        while (!(ctx_count >= 2 && o_ready) && t < TIMEOUT) begin
            @(negedge i_clk);
            t++;
        end
        if (t >= TIMEOUT) begin
            abort_on_timeout("the third pop phase");
        end else begin
            repeat (3) @(posedge i_clk);
            i_reg_clear <= 1'b1;
            @(posedge i_clk);
            i_reg_clear <= 1'b0;
            for (int r = 0; r < ROUTER_COUNT; r++) begin
                expect_q[r].delete();
            end
            // Stray valids now hit empty queues in the monitor
            repeat (20) begin
                @(negedge i_clk);
                if (o_ready || done_count != 0) begin
                    $display("Job kept running after i_reg_clear");
                    errors++;
                end
            end
            run_job(8, 4, 1, 0);
        end
    endtask

    initial begin
        int e;
        i_clk           = 1'b0;
        i_rst           = 1'b1;
        i_en            = 1'b0;
        i_reg_clear     = 1'b0;
        i_spad_write_en = 1'b0;
        i_pop_en        = 1'b0;
        i_data_in       = '0;
        i_write_addr    = '0;
        i_start_addr    = '0;
        i_addr_end      = '0;
        i_i_size        = '0;
        i_o_size        = '0;
        i_stride        = '0;
        pop_rate        = 0;
        pop_next        = 1'b0;
        errors          = 0;
        repeat (3) @(posedge i_clk);
        i_rst <= 1'b0;
        @(negedge i_clk);
        if (o_ready || o_read_done || o_context_done || o_output_done
                || o_data_valid != '0) begin
            $display("Outputs were not idle after reset");
            errors++;
        end

        e = errors;
        pop_rate = 100;
        write_map(0, 8);
        run_job(8, 4, 1, 0);
        report_test("basic", e);

        e = errors;
        pop_rate = 70;
        write_map(40, 11);
        run_job(9, 4, 2, 40);
        report_test("stride2", e);

        e = errors;
        run_job(8, 6, 1, 0);
        report_test("partial", e);

        e = errors;
        pop_rate = 40;
        write_map(100, 13);
        run_job(10, 8, 1, 100);
        report_test("backpressure", e);

        e = errors;
        abort_job();
        report_test("abort", e);

        e = errors;
        pop_rate = 80;
        write_map(0, 8);
        run_job(8, 4, 1, 0);
        report_test("rewrite", e);

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- verif/input_router_asserts.sv
/*
  Protocol checks on the router's top-level outputs.
*/
`timescale 1ns/1ps

module input_router_asserts
    import ir_pkg::*;
(
    input logic                    i_clk,
    input logic                    i_rst,
    input logic                    i_pop_en,
    input logic                    o_ready,
    input logic                    o_context_done,
    input logic                    o_output_done,
    input logic [ROUTER_COUNT-1:0] o_data_valid
);

    // Data only in the cycle after a pop taken while ready
    a_valid_after_pop: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_data_valid != '0) |-> $past(o_ready && i_pop_en))
        else $error("o_data_valid high without a pop in the ready phase");

    a_ctx_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
        o_context_done |=> !o_context_done)
        else $error("o_context_done longer than one cycle");

    a_out_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
        o_output_done |=> !o_output_done)
        else $error("o_output_done longer than one cycle");

    a_ready_reset: assert property (@(posedge i_clk) $past(i_rst) |-> !o_ready)
        else $error("o_ready high right after reset");

endmodule

bind input_router input_router_asserts u_asserts (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_pop_en       (i_pop_en),
    .o_ready        (o_ready),
    .o_context_done (o_context_done),
    .o_output_done  (o_output_done),
    .o_data_valid   (o_data_valid)
);

//--- input_router/input_router.sv
/*
  Input-side data router: scratchpad, tile reader, controller, address generator, routers.
  Job parameters must stay stable from i_en until o_output_done.
*/
`timescale 1ns/1ps

module input_router
    import ir_pkg::*;
(
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  logic                      i_en,
    input  logic                      i_reg_clear,
    input  logic                      i_spad_write_en,
    input  spad_word_t                i_data_in,
    input  word_addr_t                i_write_addr,
    input  word_addr_t                i_start_addr,
    input  word_addr_t                i_addr_end,
    input  word_addr_t                i_i_size,
    input  word_addr_t                i_o_size,
    input  word_addr_t                i_stride,
    input  logic                      i_pop_en,
    output logic                      o_read_done,
    output pixel_t [ROUTER_COUNT-1:0] o_data,
    output logic [ROUTER_COUNT-1:0]   o_data_valid,
    output logic                      o_ready,
    output logic                      o_context_done,
    output logic                      o_output_done
);

    // Scratchpad and tile reader
    spad_word_t spad_data_out;
    logic       spad_data_out_valid;
    logic       spad_read_en;
    word_addr_t spad_read_addr;
    word_addr_t tr_data_addr;

    // Controller
    logic [ROUTER_COUNT-1:0] row_id;
    word_addr_t              o_x;
    word_addr_t              o_y;
    logic                    ag_en;
    logic                    tile_read_en;
    logic                    pop_en;
    logic                    router_reg_clear;

    // Address generator and routers
    logic                        ag_valid;
    logic                        ag_skip;
    word_addr_t [WINDOW_LEN-1:0] ag_word_addr;
    lane_t [WINDOW_LEN-1:0]      ag_lane;
    logic [ROUTER_COUNT-1:0]     ag_row_id;
    logic                        data_empty;

    spad u_spad (
        .i_clk            (i_clk),
        .i_rst            (i_rst),
        .i_write_en       (i_spad_write_en),
        .i_read_en        (spad_read_en),
        .i_write_addr     (i_write_addr),
        .i_read_addr      (spad_read_addr),
        .i_data_in        (i_data_in),
        .o_data_out       (spad_data_out),
        .o_data_out_valid (spad_data_out_valid)
    );

    tile_reader u_tile_reader (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_read_en     (tile_read_en),
        .i_reg_clear   (router_reg_clear),
        .i_start_addr  (i_start_addr),
        .i_addr_end    (i_addr_end),
        .o_buf_read_en (spad_read_en),
        .o_read_done   (o_read_done),
        .o_read_addr   (spad_read_addr),
        .o_data_addr   (tr_data_addr)
    );

    ir_controller u_controller (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_en           (i_en),
        .i_reg_clear    (i_reg_clear),
        .i_pop_en       (i_pop_en),
        .i_read_done    (o_read_done),
        .i_data_empty   (data_empty),
        .i_o_size       (i_o_size),
        .i_stride       (i_stride),
        .o_row_id       (row_id),
        .o_o_x          (o_x),
        .o_o_y          (o_y),
        .o_ag_en        (ag_en),
        .o_tile_read_en (tile_read_en),
        .o_pop_en       (pop_en),
        .o_reg_clear    (router_reg_clear),
        .o_ready        (o_ready),
        .o_context_done (o_context_done),
        .o_done         (o_output_done)
    );

    address_generator u_address_gen (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_en         (ag_en),
        .i_o_x        (o_x),
        .i_o_y        (o_y),
        .i_i_size     (i_i_size),
        .i_o_size     (i_o_size),
        .i_stride     (i_stride),
        .i_start_addr (i_start_addr),
        .i_row_id     (row_id),
        .o_valid      (ag_valid),
        .o_skip       (ag_skip),
        .o_word_addr  (ag_word_addr),
        .o_lane       (ag_lane),
        .o_row_id     (ag_row_id)
    );

    row_group u_row_group (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_reg_clear  (router_reg_clear),
        .i_ag_valid   (ag_valid),
        .i_skip       (ag_skip),
        .i_data_valid (spad_data_out_valid),
        .i_pop_en     (pop_en),
        .i_row_id     (ag_row_id),
        .i_word_addr  (ag_word_addr),
        .i_lane       (ag_lane),
        .i_addr       (tr_data_addr),
        .i_data       (spad_data_out),
        .o_data       (o_data),
        .o_data_valid (o_data_valid),
        .o_data_empty (data_empty)
    );

endmodule

//--- input_router/row_group.sv
/*
  Four row routers sharing the scratchpad stream and the pop strobe.
  Each address list goes to the router named by the one-hot row id.
*/
`timescale 1ns/1ps

module row_group
    import ir_pkg::*;
(
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_reg_clear,
    input  logic                          i_ag_valid,
    input  logic                          i_skip,
    input  logic                          i_data_valid,
    input  logic                          i_pop_en,
    input  logic [ROUTER_COUNT-1:0]       i_row_id,
    input  word_addr_t [WINDOW_LEN-1:0]   i_word_addr,
    input  lane_t [WINDOW_LEN-1:0]        i_lane,
    input  word_addr_t                    i_addr,
    input  spad_word_t                    i_data,
    output pixel_t [ROUTER_COUNT-1:0]     o_data,
    output logic [ROUTER_COUNT-1:0]       o_data_valid,
    output logic                          o_data_empty
);

    logic [ROUTER_COUNT-1:0] empty;

    for (genvar r = 0; r < ROUTER_COUNT; r++) begin : g_router
        row_router u_router (
            .i_clk        (i_clk),
            .i_rst        (i_rst),
            .i_clear      (i_reg_clear),
            .i_load       (i_ag_valid && i_row_id[r]),
            .i_skip       (i_skip),
            .i_word_addr  (i_word_addr),
            .i_lane       (i_lane),
            .i_data_valid (i_data_valid),
            .i_data_addr  (i_addr),
            .i_data       (i_data),
            .i_pop        (i_pop_en),
            .o_data       (o_data[r]),
            .o_data_valid (o_data_valid[r]),
            .o_empty      (empty[r])
        );
    end

    assign o_data_empty = &empty;

endmodule

//--- input_router/row_router.sv
/*
  Holds one 3x3 window: nine word/lane pairs and their captured pixels.
  Slots not hit by any read stay zero.
*/
`timescale 1ns/1ps

module row_router
    import ir_pkg::*;
(
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic                        i_clear,
    input  logic                        i_load,
    input  logic                        i_skip,
    input  word_addr_t [WINDOW_LEN-1:0] i_word_addr,
    input  lane_t [WINDOW_LEN-1:0]      i_lane,
    input  logic                        i_data_valid,
    input  word_addr_t                  i_data_addr,
    input  spad_word_t                  i_data,
    input  logic                        i_pop,
    output pixel_t                      o_data,
    output logic                        o_data_valid,
    output logic                        o_empty
);

    word_addr_t addr_q [WINDOW_LEN];
    lane_t      lane_q [WINDOW_LEN];
    pixel_t     slot   [WINDOW_LEN];
    logic [3:0] ptr;
    logic       skip_q;

    assign o_empty = skip_q || (ptr >= 4'(WINDOW_LEN));

    // Address list and captured pixels
    always_ff @(posedge i_clk) begin
        for (int i = 0; i < WINDOW_LEN; i++) begin
            if (i_load) begin
                addr_q[i] <= i_word_addr[i];
                lane_q[i] <= i_lane[i];
                slot[i]   <= '0;
            end else if (i_data_valid && (i_data_addr == addr_q[i])) begin
                slot[i] <= i_data[int'(lane_q[i])*DATA_WIDTH +: DATA_WIDTH];
            end
        end
        if (i_pop && !o_empty) begin
            o_data <= slot[ptr];
        end
    end

    // Pop pointer, parked past the last slot when cleared
    always_ff @(posedge i_clk) begin
        if (i_rst || i_clear) begin
            ptr          <= 4'(WINDOW_LEN);
            skip_q       <= 1'b0;
            o_data_valid <= 1'b0;
        end else begin
            o_data_valid <= i_pop && !o_empty;
            if (i_load) begin
                ptr    <= '0;
                skip_q <= i_skip;
            end else if (i_pop && !o_empty) begin
                ptr <= ptr + 1'b1;
            end
        end
    end

endmodule

//--- input_router/address_generator.sv
/*
  Window addresses for the output pixel (ox + r, oy) of router r.
  Byte offsets wrap at 11 bits; maps must fit inside that range.
*/
`timescale 1ns/1ps

module address_generator
    import ir_pkg::*;
(
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_en,
    input  word_addr_t                    i_o_x,
    input  word_addr_t                    i_o_y,
    input  word_addr_t                    i_i_size,
    input  word_addr_t                    i_o_size,
    input  word_addr_t                    i_stride,
    input  word_addr_t                    i_start_addr,
    input  logic [ROUTER_COUNT-1:0]       i_row_id,
    output logic                          o_valid,
    output logic                          o_skip,
    output word_addr_t [WINDOW_LEN-1:0]   o_word_addr,
    output lane_t [WINDOW_LEN-1:0]        o_lane,
    output logic [ROUTER_COUNT-1:0]       o_row_id
);

    byte_addr_t x_col;
    byte_addr_t row_base;
    byte_addr_t col_base;
    byte_addr_t offset [WINDOW_LEN];

    always_comb begin
        x_col = byte_addr_t'(i_o_x);
        for (int r = 0; r < ROUTER_COUNT; r++) begin
            if (i_row_id[r]) begin
                x_col = byte_addr_t'(i_o_x) + byte_addr_t'(r);
            end
        end
        row_base = byte_addr_t'(i_o_y) * byte_addr_t'(i_stride);
        col_base = x_col * byte_addr_t'(i_stride);
        // ky-major, then kx
        for (int k = 0; k < WINDOW_LEN; k++) begin
            offset[k] = (row_base + byte_addr_t'(k / KERNEL_SIZE)) * byte_addr_t'(i_i_size)
                      + col_base + byte_addr_t'(k % KERNEL_SIZE);
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_en;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_en) begin
            o_row_id <= i_row_id;
            o_skip   <= x_col >= byte_addr_t'(i_o_size);
            for (int k = 0; k < WINDOW_LEN; k++) begin
                o_word_addr[k] <= i_start_addr + offset[k][BYTE_ADDR_WIDTH-1:$clog2(LANES)];
                o_lane[k]      <= offset[k][$clog2(LANES)-1:0];
            end
        end
    end

endmodule

//--- input_router/ir_controller.sv
/*
  Sequences one context at a time: clear, load, read, settle, pop.
  A start with a zero output size or stride is ignored.
*/
`timescale 1ns/1ps

module ir_controller
    import ir_pkg::*;
(
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    i_en,
    input  logic                    i_reg_clear,
    input  logic                    i_pop_en,
    input  logic                    i_read_done,
    input  logic                    i_data_empty,
    input  word_addr_t              i_o_size,
    input  word_addr_t              i_stride,
    output logic [ROUTER_COUNT-1:0] o_row_id,
    output word_addr_t              o_o_x,
    output word_addr_t              o_o_y,
    output logic                    o_ag_en,
    output logic                    o_tile_read_en,
    output logic                    o_pop_en,
    output logic                    o_reg_clear,
    output logic                    o_ready,
    output logic                    o_context_done,
    output logic                    o_done
);

    ir_state_t state, next_state;
    logic [2:0] load_cnt;
    logic       row_wrap;
    logic       last_ctx;

    // Row ends once ox + 4 reaches the output side
    assign row_wrap = ({1'b0, o_o_x} + (ADDR_WIDTH+1)'(ROUTER_COUNT)) >= {1'b0, i_o_size};
    assign last_ctx = row_wrap && (o_o_y == i_o_size - 1'b1);

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (i_en && (i_o_size != '0) && (i_stride != '0)) begin
                    next_state = CLEAR;
                end
            end
            CLEAR:  next_state = LOAD;
            // Four router loads plus one cycle for the last address
            LOAD: begin
                if (load_cnt == 3'(ROUTER_COUNT)) begin
                    next_state = READ;
                end
            end
            READ: begin
                if (i_read_done) begin
                    next_state = SETTLE;
                end
            end
            SETTLE: next_state = POP;
            POP: begin
                if (i_data_empty) begin
                    next_state = NEXT;
                end
            end
            NEXT:    next_state = last_ctx ? IDLE : CLEAR;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst || i_reg_clear) begin
            state    <= IDLE;
            load_cnt <= '0;
            o_o_x    <= '0;
            o_o_y    <= '0;
        end else begin
            state <= next_state;
            if (state == LOAD) begin
                load_cnt <= load_cnt + 1'b1;
            end else begin
                load_cnt <= '0;
            end
            if (state == IDLE) begin
                o_o_x <= '0;
                o_o_y <= '0;
            end else if (state == NEXT) begin
                if (row_wrap) begin
                    o_o_x <= '0;
                    o_o_y <= o_o_y + 1'b1;
                end else begin
                    o_o_x <= o_o_x + word_addr_t'(ROUTER_COUNT);
                end
            end
        end
    end

    assign o_ag_en        = (state == LOAD) && (load_cnt < 3'(ROUTER_COUNT));
    assign o_row_id       = o_ag_en ? (ROUTER_COUNT'(1) << load_cnt[1:0]) : '0;
    assign o_tile_read_en = (state == LOAD) && (load_cnt == 3'(ROUTER_COUNT));
    assign o_reg_clear    = (state == CLEAR) || i_reg_clear;
    assign o_ready        = (state == POP);
    assign o_pop_en       = o_ready && i_pop_en;
    assign o_context_done = (state == NEXT);
    assign o_done         = (state == NEXT) && last_ctx;

endmodule

//--- input_router/tile_reader.sv
/*
  Reads the word range start..end inclusive, one word per cycle.
  End must not be below start; the range is not wrapped.
*/
`timescale 1ns/1ps

module tile_reader
    import ir_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_read_en,
    input  logic       i_reg_clear,
    input  word_addr_t i_start_addr,
    input  word_addr_t i_addr_end,
    output logic       o_buf_read_en,
    output logic       o_read_done,
    output word_addr_t o_read_addr,
    output word_addr_t o_data_addr
);

    logic       busy;
    word_addr_t addr_q;
    word_addr_t end_q;

    always_ff @(posedge i_clk) begin
        if (i_rst || i_reg_clear) begin
            busy        <= 1'b0;
            o_read_done <= 1'b0;
        end else begin
            o_read_done <= busy && (addr_q == end_q);
            if (i_read_en) begin
                busy <= 1'b1;
            end else if (busy && (addr_q == end_q)) begin
                busy <= 1'b0;
            end
        end
    end

    // Address counter and the copy aligned with scratchpad data
    always_ff @(posedge i_clk) begin
        if (i_read_en) begin
            addr_q <= i_start_addr;
            end_q  <= i_addr_end;
        end else if (busy) begin
            addr_q <= addr_q + 1'b1;
        end
        o_data_addr <= addr_q;
    end

    assign o_buf_read_en = busy;
    assign o_read_addr   = addr_q;

endmodule

//--- input_router/spad.sv
/*
  Single-port-per-direction scratchpad, no reset on the array.
  Read data and valid arrive one cycle after the read enable.
*/
`timescale 1ns/1ps

module spad
    import ir_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_write_en,
    input  logic       i_read_en,
    input  word_addr_t i_write_addr,
    input  word_addr_t i_read_addr,
    input  spad_word_t i_data_in,
    output spad_word_t o_data_out,
    output logic       o_data_out_valid
);

    spad_word_t mem [2**ADDR_WIDTH];

    always_ff @(posedge i_clk) begin
        if (i_write_en) begin
            mem[i_write_addr] <= i_data_in;
        end
        if (i_read_en) begin
            o_data_out <= mem[i_read_addr];
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_data_out_valid <= 1'b0;
        end else begin
            o_data_out_valid <= i_read_en;
        end
    end

endmodule

//--- common/ir_pkg.sv
/*
  Shared sizes and types for the input router.
  Widths assume a 256-word scratchpad and maps of up to 2048 pixels.
*/
package ir_pkg;

    localparam int ROUTER_COUNT    = 4;
    localparam int SPAD_DATA_WIDTH = 64;
    localparam int ADDR_WIDTH      = 8;
    localparam int DATA_WIDTH      = 8;
    localparam int LANES           = SPAD_DATA_WIDTH / DATA_WIDTH;
    localparam int KERNEL_SIZE     = 3;
    localparam int WINDOW_LEN      = KERNEL_SIZE * KERNEL_SIZE;
    localparam int BYTE_ADDR_WIDTH = 11;

    typedef logic [ADDR_WIDTH-1:0]      word_addr_t;
    typedef logic [SPAD_DATA_WIDTH-1:0] spad_word_t;
    typedef logic [DATA_WIDTH-1:0]      pixel_t;
    typedef logic [$clog2(LANES)-1:0]   lane_t;
    typedef logic [BYTE_ADDR_WIDTH-1:0] byte_addr_t;

    // Controller sequence per context
    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        LOAD,
        READ,
        SETTLE,
        POP,
        NEXT
    } ir_state_t;

endpackage
